//--- rtl/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

////////////////////////////////////////
// Serial line timing
////////////////////////////////////////

`define UART_CLKS_PER_BIT 16        // Clock cycles per serial bit

// Receive buffer depth in bytes
`define UART_FIFO_DEPTH   8

////////////////////////////////////////
// Wishbone register map
////////////////////////////////////////

`define UART_WB_DW        8         // Data bus width
`define UART_WB_AW        2         // Word address width

`define UART_ADDR_DATA    0
`define UART_ADDR_STATUS  1
`define UART_ADDR_CTRL    2

// STATUS register bit positions
`define UART_ST_RX_EMPTY  0
`define UART_ST_RX_FULL   1
`define UART_ST_TX_BUSY   2
`define UART_ST_PAR_ERR   3         // Sticky
`define UART_ST_FRM_ERR   4         // Sticky
`define UART_ST_OVERRUN   5         // Sticky

`endif

//--- rtl/uart_pkg.sv
`default_nettype none
`include "uart_defs.svh"

package uart_pkg;

    // Parity mode as held in CTRL[1:0], code 3 behaves like none
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2
    } parity_t;

    typedef enum logic [`UART_WB_AW-1:0] {
        REG_DATA   = `UART_ADDR_DATA,
        REG_STATUS = `UART_ADDR_STATUS,
        REG_CTRL   = `UART_ADDR_CTRL
    } reg_addr_t;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

//--- rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_tx
(
    input  logic              clk,
    input  logic              rst,
    input  logic              tx_start,
    input  logic [7:0]        tx_byte,
    input  uart_pkg::parity_t parity,
    input  logic              two_stop,
    output logic              tx,
    output logic              tx_busy
);

    localparam int BIT_CLKS = `UART_CLKS_PER_BIT;
    localparam int CNT_W    = $clog2(BIT_CLKS);

    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    bit_cnt;           // Clocks spent in the current bit
    logic [2:0]          data_idx;
    logic                stop_idx;          // High during the second stop bit
    logic [7:0]          data_q;
    uart_pkg::parity_t   par_mode;
    logic                stop2_q;
    logic                bit_done;
    logic                par_en;
    logic                par_bit;

    assign bit_done = (bit_cnt == CNT_W'(BIT_CLKS - 1));
    assign par_en   = (par_mode == uart_pkg::PARITY_EVEN) || (par_mode == uart_pkg::PARITY_ODD);
    assign par_bit  = (par_mode == uart_pkg::PARITY_ODD) ? ~^data_q : ^data_q;

    // Frame settings are frozen for the whole frame
    always_ff @(posedge clk)
    begin
        if (tx_start && state == uart_pkg::TX_IDLE)
        begin
            data_q   <= tx_byte;
            par_mode <= parity;
            stop2_q  <= two_stop;
        end
    end

    ////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= uart_pkg::TX_IDLE;
            tx       <= 1'b1;                   // Line idles high
            tx_busy  <= 1'b0;
            bit_cnt  <= '0;
            data_idx <= '0;
            stop_idx <= 1'b0;
        end
        else if (state == uart_pkg::TX_IDLE)
        begin
            if (tx_start)
            begin
                state   <= uart_pkg::TX_START;
                tx      <= 1'b0;                // Start bit
                tx_busy <= 1'b1;
                bit_cnt <= '0;
            end
        end
        else
        begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            if (bit_done)
            begin
                case (state)
                    uart_pkg::TX_START:
                    begin
                        state    <= uart_pkg::TX_DATA;
                        tx       <= data_q[0];      // LSB first
                        data_idx <= 3'd0;
                    end
                    uart_pkg::TX_DATA:
                    begin
                        if (data_idx == 3'd7)
                        begin
                            state    <= par_en ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
                            tx       <= par_en ? par_bit : 1'b1;
                            stop_idx <= 1'b0;
                        end
                        else
                        begin
                            data_idx <= data_idx + 3'd1;
                            tx       <= data_q[data_idx + 3'd1];
                        end
                    end
                    uart_pkg::TX_PARITY:
                    begin
                        state <= uart_pkg::TX_STOP;
                        tx    <= 1'b1;
                    end
                    default:
                    begin
                        // Stop bit finished, maybe one more
                        if (stop2_q && !stop_idx)
                        begin
                            stop_idx <= 1'b1;
                        end
                        else
                        begin
                            state   <= uart_pkg::TX_IDLE;
                            tx_busy <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_rx
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    input  uart_pkg::parity_t parity,
    output logic              rx_valid,
    output logic [7:0]        rx_byte,
    output logic              par_err,
    output logic              frm_err
);

    localparam int BIT_CLKS  = `UART_CLKS_PER_BIT;
    localparam int HALF_CLKS = BIT_CLKS / 2;
    localparam int CNT_W     = $clog2(BIT_CLKS);

    uart_pkg::rx_state_t state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [2:0]          data_idx;
    logic                rx_meta;
    logic                rx_sync;
    logic                rx_prev;           // Previous synchronized sample for edge detect
    logic                par_bad;
    logic                par_en;
    logic                par_exp;
    logic                bit_done;
    logic                half_done;

    assign bit_done  = (bit_cnt == CNT_W'(BIT_CLKS - 1));
    assign half_done = (bit_cnt == CNT_W'(HALF_CLKS - 1));
    assign par_en    = (parity == uart_pkg::PARITY_EVEN) || (parity == uart_pkg::PARITY_ODD);
    assign par_exp   = (parity == uart_pkg::PARITY_ODD) ? ~^rx_byte : ^rx_byte;

    // Two-flop synchronizer, preset to the idle level
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::RX_DATA && bit_done)
        begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    ////////////////////////////////////////
    // Frame sampler
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= uart_pkg::RX_IDLE;
            bit_cnt  <= '0;
            data_idx <= '0;
            par_bad  <= 1'b0;
            rx_valid <= 1'b0;
            par_err  <= 1'b0;
            frm_err  <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            par_err  <= 1'b0;
            frm_err  <= 1'b0;
            bit_cnt  <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE:
                begin
                    bit_cnt <= '0;
                    if (rx_prev && !rx_sync)    // Falling edge
                    begin
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START:
                begin
                    if (half_done)
                    begin
                        bit_cnt <= '0;
                        // A high line here was only a glitch
                        state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        data_idx <= 3'd0;
                        par_bad  <= 1'b0;
                    end
                end
                uart_pkg::RX_DATA:
                begin
                    if (bit_done)
                    begin
                        data_idx <= data_idx + 3'd1;
                        if (data_idx == 3'd7)
                        begin
                            state <= par_en ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_PARITY:
                begin
                    if (bit_done)
                    begin
                        par_bad <= (rx_sync != par_exp);
                        state   <= uart_pkg::RX_STOP;
                    end
                end
                default:
                begin
                    // Decide at the middle of the first stop bit
                    if (bit_done)
                    begin
                        state    <= uart_pkg::RX_IDLE;
                        frm_err  <= !rx_sync;
                        par_err  <= par_bad;
                        rx_valid <= rx_sync && !par_bad;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module rx_fifo
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
)
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       empty,
    output logic       full,
    output logic       overrun
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == (AW + 1)'(DEPTH));
    assign pop_data = mem[rd_ptr];              // Show-ahead

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            overrun <= push && full;            // Byte is lost
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_wb_regs
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`UART_WB_AW-1:0] wb_adr,
    input  logic [`UART_WB_DW-1:0] wb_dat_i,
    output logic [`UART_WB_DW-1:0] wb_dat_o,
    output logic                   wb_ack,
    output logic                   tx_start,
    output logic [7:0]             tx_byte,
    input  logic                   tx_busy,
    output uart_pkg::parity_t      parity,
    output logic                   two_stop,
    output logic                   fifo_pop,
    input  logic [7:0]             fifo_data,
    input  logic                   fifo_empty,
    input  logic                   fifo_full,
    input  logic                   par_err,
    input  logic                   frm_err,
    input  logic                   overrun
);

    uart_pkg::reg_addr_t    addr;
    logic                   req;
    logic                   take;       // Access completes, ack follows next cycle
    logic                   done;       // Ack already given for this strobe
    logic                   wr_data;
    logic                   wr_status;
    logic                   par_flag;
    logic                   frm_flag;
    logic                   ovr_flag;
    logic [`UART_WB_DW-1:0] status;
    logic [`UART_WB_DW-1:0] rd_data;

    assign addr      = uart_pkg::reg_addr_t'(wb_adr);
    assign wr_data   = wb_we && (addr == uart_pkg::REG_DATA);
    assign req       = wb_cyc && wb_stb && !wb_ack && !done;
    assign take      = req && !(wr_data && tx_busy);    // Hold off while the line is busy
    assign wr_status = take && wb_we && (addr == uart_pkg::REG_STATUS);

    assign tx_start = take && wr_data;
    assign tx_byte  = wb_dat_i;
    assign fifo_pop = take && !wb_we && (addr == uart_pkg::REG_DATA) && !fifo_empty;

    always_comb
    begin
        status                    = '0;
        status[`UART_ST_RX_EMPTY] = fifo_empty;
        status[`UART_ST_RX_FULL]  = fifo_full;
        status[`UART_ST_TX_BUSY]  = tx_busy;
        status[`UART_ST_PAR_ERR]  = par_flag;
        status[`UART_ST_FRM_ERR]  = frm_flag;
        status[`UART_ST_OVERRUN]  = ovr_flag;
    end

    always_comb
    begin
        case (addr)
            uart_pkg::REG_DATA:   rd_data = fifo_empty ? '0 : fifo_data;
            uart_pkg::REG_STATUS: rd_data = status;
            uart_pkg::REG_CTRL:   rd_data = {5'b0, two_stop, parity};
            default:              rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            wb_dat_o <= rd_data;
        end
    end

    ////////////////////////////////////////
    // Handshake, CTRL and sticky errors
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack   <= 1'b0;
            done     <= 1'b0;
            parity   <= uart_pkg::PARITY_NONE;
            two_stop <= 1'b0;
            par_flag <= 1'b0;
            frm_flag <= 1'b0;
            ovr_flag <= 1'b0;
        end
        else
        begin
            wb_ack <= take;
            done   <= (done || wb_ack) && wb_cyc && wb_stb;     // Rearm once stb drops
            if (take && wb_we && addr == uart_pkg::REG_CTRL)
            begin
                parity   <= uart_pkg::parity_t'(wb_dat_i[1:0]);
                two_stop <= wb_dat_i[2];
            end
            // New errors win over a clear in the same cycle
            par_flag <= par_err || (par_flag && !(wr_status && wb_dat_i[`UART_ST_PAR_ERR]));
            frm_flag <= frm_err || (frm_flag && !(wr_status && wb_dat_i[`UART_ST_FRM_ERR]));
            ovr_flag <= overrun || (ovr_flag && !(wr_status && wb_dat_i[`UART_ST_OVERRUN]));
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_wb_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module uart_wb_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`UART_WB_AW-1:0] wb_adr,
    input  logic [`UART_WB_DW-1:0] wb_dat_i,
    output logic [`UART_WB_DW-1:0] wb_dat_o,
    output logic                   wb_ack,
    input  logic                   rx,
    output logic                   tx
);

    logic              tx_start;
    logic [7:0]        tx_byte;
    logic              tx_busy;
    uart_pkg::parity_t parity;
    logic              two_stop;
    logic              rx_valid;
    logic [7:0]        rx_byte;
    logic              par_err;
    logic              frm_err;
    logic              fifo_pop;
    logic [7:0]        fifo_data;
    logic              fifo_empty;
    logic              fifo_full;
    logic              overrun;

    // Host side
    uart_wb_regs regs_inst
    (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx_busy    (tx_busy),
        .parity     (parity),
        .two_stop   (two_stop),
        .fifo_pop   (fifo_pop),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .par_err    (par_err),
        .frm_err    (frm_err),
        .overrun    (overrun)
    );

    uart_tx tx_inst
    (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .parity   (parity),
        .two_stop (two_stop),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx rx_inst
    (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .parity   (parity),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .par_err  (par_err),
        .frm_err  (frm_err)
    );

    // Only good frames reach the buffer
    rx_fifo #(.DEPTH(`UART_FIFO_DEPTH)) fifo_inst
    (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_valid),
        .push_data (rx_byte),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .overrun   (overrun)
    );

endmodule

`default_nettype wire

//--- testbench/tb_uart_wb_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "uart_defs.svh"

module tb_uart_wb_top;

    localparam int B       = `UART_CLKS_PER_BIT;
    localparam int DEPTH   = `UART_FIFO_DEPTH;
    localparam int TIMEOUT = 4000;              // Cycles or polls allowed per wait

    // CTRL[1:0] parity codes
    localparam logic [1:0] PAR_NONE = 2'd0;
    localparam logic [1:0] PAR_EVEN = 2'd1;
    localparam logic [1:0] PAR_ODD  = 2'd2;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`UART_WB_AW-1:0] wb_adr;
    logic [`UART_WB_DW-1:0] wb_dat_i;
    logic [`UART_WB_DW-1:0] wb_dat_o;
    logic                   wb_ack;
    logic                   rx;
    logic                   tx;
    logic                   loop_sel;           // High feeds tx back into rx
    logic                   drv_line;           // Serial driver output
    logic [7:0]             sent_q [$];
    logic [7:0]             line_q [$];         // Bytes seen on tx by the decoder
    int                     errors = 0;
    int                     checks = 0;
    int                     cycle = 0;
    int                     last_ack;
    integer                 seed = 32'h3dd766fa;

    assign rx = loop_sel ? tx : drv_line;

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    uart_wb_top uart_wb_top_inst
    (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .rx       (rx),
        .tx       (tx)
    );

    ////////////////////////////////////////
    // Checking and reference helpers
    ////////////////////////////////////////

    task automatic check_eq(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("ERR %s expected 0x%02h actual 0x%02h", name, expected, actual);
        end
    endtask

    // Even parity makes the ones in data plus parity even
    function automatic logic parity_bit(input logic [7:0] data, input logic [1:0] mode);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++)
        begin
            ones += data[i];
        end
        if (mode == PAR_ODD)
        begin
            return (ones % 2) == 0;
        end
        else
        begin
            return (ones % 2) == 1;
        end
    endfunction

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    ////////////////////////////////////////
    // Wishbone host
    ////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        int t;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        t = 0;
        @(negedge clk);
        while (!wb_ack && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!wb_ack)
        begin
            errors++;
            $display("Bus access to address %0d was never acknowledged", adr);
        end
        rdata    = wb_dat_o;
        last_ack = cycle;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_eq("wb_ack", 8'h00, wb_ack);      // Ack lasts one cycle
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [7:0] data);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] data);
        bus_cycle(1'b0, adr, 8'h00, data);
    endtask

    task automatic wait_rx_ready();
        logic [7:0] st;
        int t;
        t = 0;
        wb_read(`UART_ADDR_STATUS, st);
        while (st[`UART_ST_RX_EMPTY] && t < TIMEOUT)
        begin
            wb_read(`UART_ADDR_STATUS, st);
            t++;
        end
        if (st[`UART_ST_RX_EMPTY])
        begin
            errors++;
            $display("No byte arrived in the receive FIFO");
        end
    endtask

    ////////////////////////////////////////
    // Serial line
    ////////////////////////////////////////

    // Samples tx at mid-bit, one frame per call
    task automatic decode_frame(input logic [1:0] mode, input logic two);
        logic [7:0] data;
        int t;
        t = 0;
        @(negedge clk);
        while (tx && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (tx)
        begin
            errors++;
            $display("No start bit appeared on tx");
        end
        else
        begin
            repeat (B / 2 - 1) @(negedge clk);
            check_eq("tx start", 8'h00, tx);
            for (int i = 0; i < 8; i++)
            begin
                repeat (B) @(negedge clk);
                data[i] = tx;                   // LSB first
            end
            if (mode == PAR_EVEN || mode == PAR_ODD)
            begin
                repeat (B) @(negedge clk);
                check_eq("tx parity", parity_bit(data, mode), tx);
            end
            repeat (B) @(negedge clk);
            check_eq("tx stop", 8'h01, tx);
            if (two)
            begin
                repeat (B) @(negedge clk);
                check_eq("tx stop2", 8'h01, tx);
            end
            line_q.push_back(data);
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input logic use_par,
                              input logic par, input logic stop_level);
        logic [10:0] bits;
        int n;
        n    = use_par ? 11 : 10;
        bits = use_par ? {stop_level, par, data, 1'b0} : {1'b1, stop_level, data, 1'b0};
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            drv_line <= bits[i];
            repeat (B - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_line <= 1'b1;                       // One idle bit after the frame
        repeat (B - 1) @(posedge clk);
    endtask

    // Drains the FIFO against sent_q and the decoder's record
    task automatic read_back_all();
        logic [7:0] rd;
        check_eq("decoded count", sent_q.size(), line_q.size());
        for (int i = 0; i < sent_q.size(); i++)
        begin
            if (i < line_q.size())
            begin
                check_eq("tx byte", sent_q[i], line_q[i]);
            end
            wait_rx_ready();
            wb_read(`UART_ADDR_DATA, rd);
            check_eq("DATA", sent_q[i], rd);
        end
        wb_read(`UART_ADDR_STATUS, rd);
        check_eq("STATUS", 8'h01, rd);
    endtask

    task automatic loopback_run(input logic [1:0] mode, input logic two);
        logic [7:0] rd;
        logic [7:0] b;
        wb_write(`UART_ADDR_CTRL, {5'b0, two, mode});
        wb_read(`UART_ADDR_CTRL, rd);
        check_eq("CTRL", {5'b0, two, mode}, rd);
        sent_q.delete();
        line_q.delete();
        fork
            begin
                for (int i = 0; i < 3; i++)
                begin
                    b = rand_byte();
                    sent_q.push_back(b);
                    wb_write(`UART_ADDR_DATA, b);
                end
            end
            begin
                for (int i = 0; i < 3; i++)
                begin
                    decode_frame(mode, two);
                end
            end
        join
        read_back_all();
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [7:0] st;
        logic [7:0] b;
        int first_ack;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        loop_sel = 1'b1;
        drv_line = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("tx", 8'h01, tx);
        check_eq("wb_ack", 8'h00, wb_ack);
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h01, st);

        for (int p = 0; p < 3; p++)
        begin
            loopback_run(p[1:0], 1'b0);
            loopback_run(p[1:0], 1'b1);
        end

        // Second write must wait out the first frame
        wb_write(`UART_ADDR_CTRL, {5'b0, 1'b0, PAR_NONE});
        sent_q.delete();
        line_q.delete();
        sent_q.push_back(rand_byte());
        sent_q.push_back(rand_byte());
        fork
            begin
                wb_write(`UART_ADDR_DATA, sent_q[0]);
                first_ack = last_ack;
                wb_write(`UART_ADDR_DATA, sent_q[1]);
                checks++;
                assert (last_ack - first_ack >= 10 * B)
                else
                begin
                    errors++;
                    $display("Second DATA write was acknowledged while tx was busy");
                end
                // First byte is back, second frame on the line
                wb_read(`UART_ADDR_STATUS, st);
                check_eq("STATUS", 8'h04, st);
            end
            begin
                decode_frame(PAR_NONE, 1'b0);
                decode_frame(PAR_NONE, 1'b0);
            end
        join
        read_back_all();

        @(posedge clk);
        loop_sel <= 1'b0;
        wb_write(`UART_ADDR_CTRL, {5'b0, 1'b0, PAR_EVEN});
        b = rand_byte();
        send_frame(b, 1'b1, ~parity_bit(b, PAR_EVEN), 1'b1);   // Wrong parity
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h09, st);
        wb_write(`UART_ADDR_STATUS, 8'h08);
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h01, st);

        wb_write(`UART_ADDR_CTRL, {5'b0, 1'b0, PAR_NONE});
        send_frame(rand_byte(), 1'b0, 1'b0, 1'b0);             // Stop bit low
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h11, st);
        wb_write(`UART_ADDR_STATUS, 8'h10);
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h01, st);

        // Overrun, the last two bytes are lost
        sent_q.delete();
        for (int i = 0; i < DEPTH + 2; i++)
        begin
            b = rand_byte();
            sent_q.push_back(b);
            send_frame(b, 1'b0, 1'b0, 1'b1);
        end
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h22, st);
        for (int i = 0; i < DEPTH; i++)
        begin
            wb_read(`UART_ADDR_DATA, b);
            check_eq("DATA", sent_q[i], b);
        end
        wb_read(`UART_ADDR_DATA, b);
        check_eq("DATA", 8'h00, b);
        wb_read(`UART_ADDR_STATUS, st);
        check_eq("STATUS", 8'h21, st);

        finish_run();
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/rx_fifo.sv
rtl/uart_wb_regs.sv
rtl/uart_wb_top.sv
testbench/tb_uart_wb_top.sv
